// File: hdl/mpu_pkg.sv
`default_nettype none

package mpu_pkg;

    // Task and region sizing
    localparam int TASKS = 8;
    localparam int ROWS = 4;
    localparam int ID_W = 3;
    localparam int ADDR_W = 16;
    localparam int PRIO_W = 8;
    localparam int DESC_W = 32;

    // CSR address of task 0, row 0
    localparam logic [11:0] CSR_BASE = 12'h400;

    // Result queue and credit sizing
    localparam int QUEUE_DEPTH = 2;
    localparam int RSP_CREDITS = 2;
    localparam int QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(RSP_CREDITS + 1);

    // Descriptor layout, base is a word address
    localparam int DESC_BASE_LSB = 0;
    localparam int DESC_BASE_MSB = 13;
    localparam int DESC_LEN_LSB = 14;
    localparam int DESC_LEN_MSB = 29;
    localparam int DESC_WR_BIT = 30;
    localparam int DESC_RD_BIT = 31;

    // Major opcodes of the memory instructions
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } mem_op_t;

    // Same encoding as funct3 of csrrw, csrrs and csrrc
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_t;

endpackage

`default_nettype wire

// File: hdl/mpu_region_file.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_region_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  csr_en,
    input  logic [11:0]           csr_addr,
    input  mpu_pkg::csr_op_t      csr_op,
    input  logic [31:0]           csr_data,
    output logic [mpu_pkg::TASKS*mpu_pkg::ROWS*mpu_pkg::DESC_W-1:0] regions
);

    import mpu_pkg::*;

    logic [11:0]             csr_offs;
    logic                    csr_hit;
    logic [ID_W-1:0]         csr_task;
    logic [$clog2(ROWS)-1:0] csr_row;
    int unsigned             desc_idx;
    logic [DESC_W-1:0]       cur_desc;
    logic [DESC_W-1:0]       new_desc;

    // Address decode into task and row
    assign csr_offs = csr_addr - CSR_BASE;
    assign csr_hit  = (csr_addr >= CSR_BASE) && (int'(csr_offs) < TASKS * ROWS);
    assign csr_row  = csr_offs[$clog2(ROWS)-1:0];
    assign csr_task = csr_offs[$clog2(ROWS) +: ID_W];
    assign desc_idx = int'(csr_task) * ROWS + int'(csr_row);

    // Read-modify-write of the addressed descriptor
    always_comb begin
        cur_desc = regions[desc_idx*DESC_W +: DESC_W];
        case (csr_op)
            CSR_WRITE: new_desc = csr_data;
            CSR_SET:   new_desc = cur_desc | csr_data;
            CSR_CLEAR: new_desc = cur_desc & ~csr_data;
            default:   new_desc = cur_desc;
        endcase
    end

    // All descriptors clear on reset so nothing is granted
    always_ff @(posedge clk) begin
        if (reset) begin
            regions <= '0;
        end else if (csr_en && csr_hit) begin
            regions[desc_idx*DESC_W +: DESC_W] <= new_desc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mpu_frame_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_frame_tracker (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   ctx_valid,
    input  logic [mpu_pkg::ID_W-1:0]               ctx_id,
    input  logic [mpu_pkg::PRIO_W-1:0]             ctx_prio,
    input  logic [mpu_pkg::ADDR_W-1:0]             ctx_sp,
    output logic [mpu_pkg::TASKS*mpu_pkg::ADDR_W-1:0] frame_bases
);

    import mpu_pkg::*;

    logic [PRIO_W-1:0] last_prio;
    logic              prio_change;

    // Only a new priority level opens a new stack frame
    assign prio_change = ctx_valid && (ctx_prio != last_prio);

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_bases <= '0;
            last_prio   <= '0;
        end else if (prio_change) begin
            frame_bases[int'(ctx_id)*ADDR_W +: ADDR_W] <= ctx_sp;
            last_prio <= ctx_prio;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mpu_region_match.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_region_match (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid,
    input  logic [mpu_pkg::ADDR_W-1:0]          req_addr,
    input  logic [6:0]                          req_op,
    input  logic [mpu_pkg::ID_W-1:0]            req_id,
    input  logic [mpu_pkg::TASKS*mpu_pkg::ROWS*mpu_pkg::DESC_W-1:0] regions,
    output logic                                s1_valid,
    output logic [mpu_pkg::ADDR_W-1:0]          s1_addr,
    output logic [6:0]                          s1_op,
    output logic [mpu_pkg::ID_W-1:0]            s1_id,
    output logic                                s1_grant
);

    import mpu_pkg::*;

    logic [ROWS*DESC_W-1:0] task_desc;
    logic [DESC_W-1:0]      row_desc [ROWS];
    logic [ADDR_W-1:0]      bot_addr [ROWS];
    logic [ADDR_W-1:0]      top_addr [ROWS];
    logic [ROWS-1:0]        row_hit;
    logic                   grant;

    // Descriptors of the requesting task only
    assign task_desc = regions[int'(req_id)*ROWS*DESC_W +: ROWS*DESC_W];

    always_comb begin
        grant = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            row_desc[r] = task_desc[r*DESC_W +: DESC_W];
            bot_addr[r] = {row_desc[r][DESC_BASE_MSB:DESC_BASE_LSB], 2'b00};
            // Top wraps in 16 bits, inclusive bound
            top_addr[r] = bot_addr[r] + row_desc[r][DESC_LEN_MSB:DESC_LEN_LSB];
            row_hit[r]  = (req_addr >= bot_addr[r]) && (req_addr <= top_addr[r]);
            if (row_hit[r]) begin
                case (mem_op_t'(req_op))
                    OP_LOAD:  grant = grant | row_desc[r][DESC_RD_BIT];
                    OP_STORE: grant = grant | row_desc[r][DESC_WR_BIT];
                    default:  grant = grant;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    // Request payload travels with its grant
    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_addr  <= req_addr;
            s1_op    <= req_op;
            s1_id    <= req_id;
            s1_grant <= grant;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mpu_fault_decide.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_fault_decide (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   s1_valid,
    input  logic [mpu_pkg::ADDR_W-1:0]             s1_addr,
    input  logic [6:0]                             s1_op,
    input  logic [mpu_pkg::ID_W-1:0]               s1_id,
    input  logic                                   s1_grant,
    input  logic [mpu_pkg::TASKS*mpu_pkg::ADDR_W-1:0] frame_bases,
    output logic                                   s2_valid,
    output logic                                   s2_fault,
    output logic [mpu_pkg::ADDR_W-1:0]             s2_addr,
    output logic [mpu_pkg::ID_W-1:0]               s2_id
);

    import mpu_pkg::*;

    logic [ADDR_W-1:0] frame_base;
    logic              below_frame;
    logic              is_mem;
    logic              fault;

    assign frame_base  = frame_bases[int'(s1_id)*ADDR_W +: ADDR_W];
    assign below_frame = s1_addr < frame_base;
    assign is_mem      = (s1_op == OP_LOAD) || (s1_op == OP_STORE);

    // Own stack frame is always open, below it a region must grant
    assign fault = is_mem && below_frame && !s1_grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_fault <= fault;
            s2_addr  <= s1_addr;
            s2_id    <= s1_id;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mpu_result_queue.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_result_queue (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s2_valid,
    input  logic                        s2_fault,
    input  logic [mpu_pkg::ADDR_W-1:0]  s2_addr,
    input  logic [mpu_pkg::ID_W-1:0]    s2_id,
    input  logic                        rsp_credit,
    output logic                        rsp_valid,
    output logic                        rsp_fault,
    output logic [mpu_pkg::ADDR_W-1:0]  rsp_addr,
    output logic [mpu_pkg::ID_W-1:0]    rsp_id,
    output logic                        req_credit
);

    import mpu_pkg::*;

    // Entry is {fault, addr, id}
    logic [ADDR_W+ID_W:0] entries [QUEUE_DEPTH];
    logic [QPTR_W-1:0]    wr_ptr;
    logic [QPTR_W-1:0]    rd_ptr;
    logic [QCNT_W-1:0]    fill;
    logic [CRED_W-1:0]    credits;
    logic                 empty;
    logic                 full;
    logic                 pop;

    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
        logic [QPTR_W-1:0] nxt;
        if (int'(ptr) == QUEUE_DEPTH - 1) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty = (fill == '0);
    assign full  = (fill == QCNT_W'(QUEUE_DEPTH));

    // Send whenever there is both a result and a consumer credit
    assign pop        = !empty && (credits != '0);
    assign rsp_valid  = pop;
    assign req_credit = pop;
    assign {rsp_fault, rsp_addr, rsp_id} = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= CRED_W'(RSP_CREDITS);
        end else begin
            if (s2_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill    <= fill + QCNT_W'(s2_valid) - QCNT_W'(pop);
            credits <= credits + CRED_W'(rsp_credit) - CRED_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            entries[wr_ptr] <= {s2_fault, s2_addr, s2_id};
        end
    end

    // Request credits bound the pipeline, so a full queue is never written
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        s2_valid |-> !full)
        else $error("result written into a full queue");

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CRED_W'(RSP_CREDITS))
        else $error("consumer credit count above its limit");

    // Consumer may not return a credit it never spent
    a_credit_return: assert property (@(posedge clk) disable iff (reset)
        rsp_credit |-> credits != CRED_W'(RSP_CREDITS))
        else $error("credit returned while count already full");

endmodule

`default_nettype wire

// File: hdl/mpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_top (
    input  logic                        clk,
    input  logic                        reset,
    // CSR port
    input  logic                        csr_en,
    input  logic [11:0]                 csr_addr,
    input  mpu_pkg::csr_op_t            csr_op,
    input  logic [31:0]                 csr_data,
    // Context port
    input  logic                        ctx_valid,
    input  logic [mpu_pkg::ID_W-1:0]    ctx_id,
    input  logic [mpu_pkg::PRIO_W-1:0]  ctx_prio,
    input  logic [mpu_pkg::ADDR_W-1:0]  ctx_sp,
    // Request port
    input  logic                        req_valid,
    input  logic [mpu_pkg::ADDR_W-1:0]  req_addr,
    input  logic [6:0]                  req_op,
    input  logic [mpu_pkg::ID_W-1:0]    req_id,
    output logic                        req_credit,
    // Response port
    output logic                        rsp_valid,
    output logic                        rsp_fault,
    output logic [mpu_pkg::ADDR_W-1:0]  rsp_addr,
    output logic [mpu_pkg::ID_W-1:0]    rsp_id,
    input  logic                        rsp_credit
);

    import mpu_pkg::*;

    logic [TASKS*ROWS*DESC_W-1:0] regions;
    logic [TASKS*ADDR_W-1:0]      frame_bases;

    logic              s1_valid;
    logic [ADDR_W-1:0] s1_addr;
    logic [6:0]        s1_op;
    logic [ID_W-1:0]   s1_id;
    logic              s1_grant;

    logic              s2_valid;
    logic              s2_fault;
    logic [ADDR_W-1:0] s2_addr;
    logic [ID_W-1:0]   s2_id;

    mpu_region_file u_region_file (
        .clk, .reset, .csr_en, .csr_addr, .csr_op, .csr_data, .regions
    );

    mpu_frame_tracker u_frame_tracker (
        .clk, .reset, .ctx_valid, .ctx_id, .ctx_prio, .ctx_sp, .frame_bases
    );

    // Stage one, region lookup
    mpu_region_match u_region_match (
        .clk, .reset, .req_valid, .req_addr, .req_op, .req_id, .regions,
        .s1_valid, .s1_addr, .s1_op, .s1_id, .s1_grant
    );

    // Stage two, frame check and fault
    mpu_fault_decide u_fault_decide (
        .clk, .reset, .s1_valid, .s1_addr, .s1_op, .s1_id, .s1_grant, .frame_bases,
        .s2_valid, .s2_fault, .s2_addr, .s2_id
    );

    mpu_result_queue u_result_queue (
        .clk, .reset, .s2_valid, .s2_fault, .s2_addr, .s2_id, .rsp_credit,
        .rsp_valid, .rsp_fault, .rsp_addr, .rsp_id, .req_credit
    );

endmodule

`default_nettype wire

// File: testbench/mpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mpu_tb;

    import mpu_pkg::*;

    localparam logic [6:0] OP_IMM = 7'b0010011;
    // Cycle budgets, reset state through random mix
    localparam int TEST_CYCLES = 40 + 60 + 40 + 40 + 60 + 340;
    localparam int WATCHDOG_NS = (TEST_CYCLES * 4 + 200) * 4;

    logic        clk = 1'b0;
    logic        reset;
    logic        csr_en;
    logic [11:0] csr_addr;
    csr_op_t     csr_op;
    logic [31:0] csr_data;
    logic        ctx_valid;
    logic [2:0]  ctx_id;
    logic [7:0]  ctx_prio;
    logic [15:0] ctx_sp;
    logic        req_valid;
    logic [15:0] req_addr;
    logic [6:0]  req_op;
    logic [2:0]  req_id;
    logic        req_credit;
    logic        rsp_valid;
    logic        rsp_fault;
    logic [15:0] rsp_addr;
    logic [2:0]  rsp_id;
    logic        rsp_credit;

    // Reference model, expected results are {fault, addr, id}
    logic [31:0] desc [TASKS*ROWS];
    logic [15:0] fb [TASKS];
    logic [7:0]  last_prio;
    logic        p1_valid;
    logic [15:0] p1_addr;
    logic [6:0]  p1_op;
    logic [2:0]  p1_id;
    logic        p1_grant;
    logic [19:0] exp_q [$];
    logic [19:0] exp_head;
    logic [19:0] rsp_word;
    logic        sent;
    logic        cred;
    logic        exp_valid;
    int          q_count;
    int          ccnt;
    int          rcnt;
    int          credit_mode;
    int          errors;
    int          errors_at_start;
    int          tests;
    string       test_name;

    mpu_top DUT (.*);

    always #2 clk = ~clk;

    function automatic logic region_grant(input logic [15:0] addr, input logic [6:0] op,
                                          input logic [2:0] id);
        logic [31:0] d;
        logic [15:0] lo;
        logic [15:0] hi;
        logic        g;
        g = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            d  = desc[int'(id) * ROWS + r];
            lo = {d[DESC_BASE_MSB:DESC_BASE_LSB], 2'b00};
            hi = lo + d[DESC_LEN_MSB:DESC_LEN_LSB];
            if (addr >= lo && addr <= hi) begin
                if (op == OP_LOAD) g = g | d[DESC_RD_BIT];
                if (op == OP_STORE) g = g | d[DESC_WR_BIT];
            end
        end
        return g;
    endfunction

    function automatic logic [6:0] rand_op();
        case ($urandom_range(0, 2))
            0: return OP_LOAD;
            1: return OP_STORE;
            default: return OP_IMM;
        endcase
    endfunction

    // Effects of the rising edge that just passed, inputs still hold their values
    task automatic commit_edge();
        logic is_mem;
        logic fault;
        int   idx;
        int   staged;
        staged = 0;
        if (p1_valid) begin
            is_mem = (p1_op == OP_LOAD) || (p1_op == OP_STORE);
            fault  = is_mem && (p1_addr < fb[p1_id]) && !p1_grant;
            exp_q.push_back({fault, p1_addr, p1_id});
            // Sits in stage two until the next edge writes it into the queue
            staged = 1;
        end
        p1_valid = req_valid;
        if (req_valid) begin
            p1_addr  = req_addr;
            p1_op    = req_op;
            p1_id    = req_id;
            p1_grant = region_grant(req_addr, req_op, req_id);
            rcnt--;
        end
        if (sent && exp_q.size() > 0) void'(exp_q.pop_front());
        if (sent) ccnt--;
        if (cred) rcnt++;
        if (rsp_credit) ccnt++;
        if (csr_en && csr_addr >= CSR_BASE && csr_addr < CSR_BASE + TASKS * ROWS) begin
            idx = int'(csr_addr - CSR_BASE);
            case (csr_op)
                CSR_WRITE: desc[idx] = csr_data;
                CSR_SET:   desc[idx] = desc[idx] | csr_data;
                CSR_CLEAR: desc[idx] = desc[idx] & ~csr_data;
                default:   desc[idx] = desc[idx];
            endcase
        end
        if (ctx_valid && ctx_prio != last_prio) begin
            fb[ctx_id] = ctx_sp;
            last_prio  = ctx_prio;
        end
        q_count   = exp_q.size();
        exp_head  = (q_count > 0) ? exp_q[0] : '0;
        exp_valid = (q_count - staged > 0) && (ccnt > 0);
    endtask

    // One clock cycle, leaves all request side inputs idle at the falling edge
    task automatic step();
        @(negedge clk);
        commit_edge();
        rsp_word   = {rsp_fault, rsp_addr, rsp_id};
        sent       = rsp_valid;
        cred       = req_credit;
        csr_en     = 1'b0;
        ctx_valid  = 1'b0;
        req_valid  = 1'b0;
        rsp_credit = 1'b0;
        if (ccnt < RSP_CREDITS) begin
            if (credit_mode == 1 || (credit_mode == 2 && $urandom_range(0, 2) == 0))
                rsp_credit = 1'b1;
        end
    endtask

    task automatic issue(input logic [15:0] addr, input logic [6:0] op, input logic [2:0] id);
        while (rcnt == 0) step();
        req_valid = 1'b1;
        req_addr  = addr;
        req_op    = op;
        req_id    = id;
        step();
    endtask

    task automatic write_csr(input csr_op_t op, input logic [11:0] addr, input logic [31:0] data);
        csr_en   = 1'b1;
        csr_addr = addr;
        csr_op   = op;
        csr_data = data;
        step();
    endtask

    task automatic set_context(input logic [2:0] id, input logic [7:0] prio,
                               input logic [15:0] sp);
        ctx_valid = 1'b1;
        ctx_id    = id;
        ctx_prio  = prio;
        ctx_sp    = sp;
        step();
    endtask

    function automatic logic [11:0] desc_addr(input int tid, input int row);
        return 12'(int'(CSR_BASE) + tid * ROWS + row);
    endfunction

    task automatic drain();
        int n;
        n = 0;
        credit_mode = 1;
        while ((q_count > 0 || p1_valid) && n < 40) begin
            step();
            n++;
        end
        if (q_count > 0 || p1_valid) begin
            errors++;
            $display("Test %s: %0d expected results never came out", test_name, q_count);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errors_at_start) $display("Test %s finished, no errors", test_name);
        else $display("Test %s finished, %0d errors", test_name, errors - errors_at_start);
    endtask

    // A result goes out exactly when the queue holds one and credit is left
    a_rsp_valid: assert property (@(posedge clk) disable iff (reset)
        rsp_valid == exp_valid)
        else begin
            errors++;
            $display("** Error [%s] rsp_valid expected %b actual %b",
                     test_name, exp_valid, sent);
        end

    // Each result must match the oldest outstanding request
    a_rsp_order: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (q_count > 0) && (rsp_word == exp_head))
        else begin
            errors++;
            $display("** Error [%s] response expected %h actual %h",
                     test_name, exp_head, rsp_word);
        end

    a_rsp_credit: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> ccnt > 0)
        else begin
            errors++;
            $display("Test %s: a result was sent with no consumer credit left", test_name);
        end

    a_req_credit: assert property (@(posedge clk) disable iff (reset)
        req_credit == exp_valid)
        else begin
            errors++;
            $display("** Error [%s] req_credit expected %b actual %b",
                     test_name, exp_valid, cred);
        end

    task automatic test_reset_state();
        begin_test("reset_state");
        for (int i = 0; i < 20; i++) issue(16'($urandom), rand_op(), 3'($urandom));
        drain();
        end_test();
    endtask

    task automatic test_region_grants();
        logic [15:0] probes [8] = '{16'h03ff, 16'h0400, 16'h0440, 16'h0441,
                                    16'h07ff, 16'h0800, 16'h0820, 16'h0821};
        begin_test("region_grants");
        set_context(3'd3, 8'd5, 16'hf000);
        // Row 0 read and write at 0x400, row 1 write only at 0x800
        write_csr(CSR_WRITE, desc_addr(3, 0), {1'b1, 1'b1, 16'h0040, 14'h0100});
        write_csr(CSR_WRITE, desc_addr(3, 1), {1'b0, 1'b1, 16'h0020, 14'h0200});
        for (int i = 0; i < 8; i++) begin
            issue(probes[i], OP_LOAD, 3'd3);
            issue(probes[i], OP_STORE, 3'd3);
        end
        drain();
        end_test();
    endtask

    task automatic test_csr_set_clear();
        begin_test("csr_set_clear");
        write_csr(CSR_CLEAR, desc_addr(3, 0), 32'h8000_0000);
        issue(16'h0410, OP_LOAD, 3'd3);
        issue(16'h0410, OP_STORE, 3'd3);
        // Both outside the map, low offset bits alias task 3 row 0
        write_csr(CSR_WRITE, CSR_BASE - 12'd20, 32'hffff_c000);
        write_csr(CSR_SET, desc_addr(11, 0), 32'h8000_0000);
        issue(16'h0410, OP_LOAD, 3'd3);
        issue(16'h0100, OP_LOAD, 3'd3);
        issue(16'h0100, OP_STORE, 3'd3);
        drain();
        end_test();
    endtask

    task automatic test_frame_tracking();
        begin_test("frame_tracking");
        set_context(3'd5, 8'd5, 16'h8000);
        issue(16'h0100, OP_LOAD, 3'd5);
        set_context(3'd5, 8'd9, 16'h8000);
        issue(16'h0100, OP_LOAD, 3'd5);
        issue(16'h8000, OP_STORE, 3'd5);
        issue(16'h0200, OP_LOAD, 3'd3);
        set_context(3'd2, 8'd9, 16'h1000);
        issue(16'h0800, OP_LOAD, 3'd2);
        drain();
        end_test();
    endtask

    task automatic test_back_pressure();
        int n;
        begin_test("back_pressure");
        n = 0;
        while (ccnt < RSP_CREDITS && n < 10) begin
            step();
            n++;
        end
        credit_mode = 0;
        step();
        for (int i = 0; i < 2 * QUEUE_DEPTH; i++)
            issue(16'($urandom), rand_op(), 3'($urandom));
        repeat (12) step();
        if (q_count != QUEUE_DEPTH) begin
            errors++;
            $display("Test %s: %0d results should wait for credit, model holds %0d",
                     test_name, QUEUE_DEPTH, q_count);
        end
        drain();
        end_test();
    endtask

    task automatic test_random_mix();
        begin_test("random_mix");
        credit_mode = 2;
        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(0, 7) == 0) begin
                csr_en   = 1'b1;
                csr_addr = 12'(int'(CSR_BASE) - 2 + int'($urandom_range(0, 35)));
                csr_op   = csr_op_t'(2'($urandom_range(1, 3)));
                csr_data = $urandom;
            end
            if ($urandom_range(0, 7) == 0) begin
                ctx_valid = 1'b1;
                ctx_id    = 3'($urandom);
                ctx_prio  = 8'($urandom_range(0, 3));
                ctx_sp    = 16'($urandom);
            end
            if (rcnt > 0 && $urandom_range(0, 1) == 1) begin
                req_valid = 1'b1;
                req_addr  = 16'($urandom);
                req_op    = rand_op();
                req_id    = 3'($urandom);
            end
            step();
        end
        drain();
        end_test();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'ha063c227));
        reset      = 1'b1;
        csr_en     = 1'b0;
        csr_addr   = '0;
        csr_op     = CSR_WRITE;
        csr_data   = '0;
        ctx_valid  = 1'b0;
        ctx_id     = '0;
        ctx_prio   = '0;
        ctx_sp     = '0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_op     = '0;
        req_id     = '0;
        rsp_credit = 1'b0;
        for (int i = 0; i < TASKS * ROWS; i++) desc[i] = '0;
        for (int i = 0; i < TASKS; i++) fb[i] = '0;
        last_prio   = '0;
        p1_valid    = 1'b0;
        exp_head    = '0;
        exp_valid   = 1'b0;
        rsp_word    = '0;
        sent        = 1'b0;
        cred        = 1'b0;
        q_count     = 0;
        ccnt        = RSP_CREDITS;
        rcnt        = QUEUE_DEPTH;
        credit_mode = 1;
        errors      = 0;
        tests       = 0;
        test_name   = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_region_grants();
        test_csr_set_clear();
        test_frame_tracking();
        test_back_pressure();
        test_random_mix();
        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/mpu_pkg.sv
hdl/mpu_region_file.sv
hdl/mpu_frame_tracker.sv
hdl/mpu_region_match.sv
hdl/mpu_fault_decide.sv
hdl/mpu_result_queue.sv
hdl/mpu_top.sv
testbench/mpu_tb.sv

// File: Bender.yml
package:
  name: mpu

sources:
  - hdl/mpu_pkg.sv
  - hdl/mpu_region_file.sv
  - hdl/mpu_frame_tracker.sv
  - hdl/mpu_region_match.sv
  - hdl/mpu_fault_decide.sv
  - hdl/mpu_result_queue.sv
  - hdl/mpu_top.sv
  - target: test
    files:
      - testbench/mpu_tb.sv
